// File: flist.f
rtl/pdp8SeqPkg.sv
rtl/seqBus.sv
rtl/switchDebounce.sv
rtl/runControl.sv
rtl/instructionDecoder.sv
rtl/majorStateSequencer.sv
rtl/pdp8Control.sv
verif/pdp8Control_tb.sv

// File: Makefile
# Verilator build and run of the PDP-8 major-state unit testbench

VERILATOR ?= verilator
TOP       ?= pdp8Control_tb
FLIST     ?= flist.f
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing -j 0

SOURCES := $(shell grep -v '^+' $(FLIST))
SIM_BIN := $(OBJ_DIR)/V$(TOP)

.PHONY: all compile run clean

all: run

compile: $(SIM_BIN)

$(SIM_BIN): $(FLIST) $(SOURCES)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FLIST)

# The simulator status is ignored here, the log decides pass or fail
run: $(SIM_BIN)
	-./$(SIM_BIN) > $(LOG) 2>&1
	@cat $(LOG)
	@grep -qx 'TEST PASS' $(LOG) || { echo "Simulation did not pass, see $(LOG)"; exit 1; }

clean:
	rm -rf $(OBJ_DIR) $(LOG)

// File: verif/seqTrace.txt
# Columns: instruction word (octal), expected isAutoIdx, expected isInd, exec count
# word auto ind exec
0123 0 0 2
1410 1 1 2
1456 0 1 2
2617 0 1 3
3000 0 0 2
4417 1 1 3
5200 0 0 1
5407 0 1 1
6031 0 0 4
7200 0 0 6
7410 0 0 6
2411 1 1 3
0720 0 1 2
6446 0 0 4
3417 1 1 2
1020 0 0 2
4420 0 1 3
7402 0 0 6
5410 1 1 1
0407 0 1 2

// File: verif/pdp8Control_tb.sv
//--------------------------------------------------------------------------
// Testbench for the PDP-8 major-state unit, driven from an instruction trace
//--------------------------------------------------------------------------
`default_nettype none

module pdp8Control_tb;

  localparam string traceFile = "verif/seqTrace.txt";
  localparam int    phFetch   = 0;
  localparam int    phAuto1   = 1;
  localparam int    phAuto2   = 2;
  localparam int    phInd     = 3;
  localparam int    phExec1   = 4;
  localparam int    phIdle    = 15;

  logic        CLK;
  logic        RESET;
  logic        run;
  logic        halt;
  logic [11:0] instrWord;
  logic [3:0]  phase;
  logic        phaseWindow;
  logic        phaseStrobe;
  logic        running;

  logic [11:0] traceWord [$];
  int          traceAuto [$];
  int          traceInd  [$];
  int          traceExec [$];
  int          strobeLog [$];
  int          readIdx;
  int          haltIndex;
  integer      seed;
  event        strobeSeen;

  pdp8Control #(
    .debounceCount(4)
  ) i_dut (
    .CLK        (CLK),
    .RESET      (RESET),
    .run        (run),
    .halt       (halt),
    .instrWord  (instrWord),
    .phase      (phase),
    .phaseWindow(phaseWindow),
    .phaseStrobe(phaseStrobe),
    .running    (running)
  );

  initial begin
    CLK = 1'b0;
    forever #10 CLK = ~CLK;
  end

  task automatic checkValue(input int expected, input int actual, input string what);
    if (expected != actual) begin
      $display("[ERROR] %0t: %s, expected %0d, got %0d", $time, what, expected, actual);
      $display("TEST FAIL");
      $fatal(1, "Stopped at the first mismatch");
    end
  endtask

  // Memory reference with the indirect bit, IOT and operate never count
  function automatic int isIndirect(input logic [11:0] word);
    return (word[11:9] <= 3'd5 && word[8]) ? 1 : 0;
  endfunction

  // Auto-index registers are page-zero locations 010 to 017
  function automatic int isAutoIndexed(input logic [11:0] word);
    return (isIndirect(word) == 1 && !word[7] && word[6:3] == 4'b0001) ? 1 : 0;
  endfunction

  function automatic int execLength(input logic [2:0] opcode);
    case (opcode)
      3'd2, 3'd4: return 3;
      3'd5:       return 1;
      3'd6:       return 4;
      3'd7:       return 6;
      default:    return 2;
    endcase
  endfunction

  task automatic loadTrace();
    int    fd;
    int    matched;
    int    wordVal;
    int    autoVal;
    int    indVal;
    int    execVal;
    string line;
    fd = $fopen(traceFile, "r");
    if (fd == 0) begin
      $display("Cannot open the trace file %s", traceFile);
      $display("TEST FAIL");
      $fatal(1, "Missing trace");
    end else begin
      while (!$feof(fd)) begin
        line = "";
        if ($fgets(line, fd) > 0) begin
          // Header lines start with # and match no field
          matched = $sscanf(line, "%o %d %d %d", wordVal, autoVal, indVal, execVal);
          if (matched == 4) begin
            traceWord.push_back(wordVal[11:0]);
            traceAuto.push_back(autoVal);
            traceInd.push_back(indVal);
            traceExec.push_back(execVal);
          end
        end
      end
      $fclose(fd);
    end
  endtask

  // Checks window shape and logs every strobed phase
  task automatic monitorPhases();
    logic secondCycle;
    int   windowPhase;
    secondCycle = 1'b0;
    windowPhase = phIdle;
    forever begin
      @(negedge CLK);
      if (!RESET) begin
        if (phaseWindow) begin
          checkValue(int'(secondCycle), int'(phaseStrobe), "strobe position in window");
          if (secondCycle) begin
            checkValue(windowPhase, int'(phase), "phase held over its window");
          end
          windowPhase = int'(phase);
          secondCycle = ~secondCycle;
        end else begin
          checkValue(0, int'(secondCycle), "window cut short");
          checkValue(0, int'(phaseStrobe), "strobe outside a window");
          checkValue(phIdle, int'(phase), "phase outside a window");
        end
        if (phaseStrobe) begin
          strobeLog.push_back(int'(phase));
          -> strobeSeen;
        end
      end
    end
  endtask

  task automatic watchdog(input int limit);
    repeat (limit) @(posedge CLK);
    $display("Timeout: the run did not finish within %0d clock cycles", limit);
    $display("TEST FAIL");
    $fatal(1, "Watchdog expired");
  endtask

  task automatic nextStrobedPhase(output int ph);
    while (readIdx >= strobeLog.size()) begin
      @(strobeSeen);
    end
    ph = strobeLog[readIdx];
    readIdx++;
  endtask

  task automatic applyRun(input int cycles);
    @(posedge CLK);
    run <= 1'b1;
    repeat (cycles) @(posedge CLK);
    run <= 1'b0;
  endtask

  task automatic waitForRunning(input logic level);
    @(negedge CLK);
    while (running !== level) begin
      @(negedge CLK);
    end
  endtask

  task automatic expectQuiet(input int cycles);
    repeat (cycles) @(negedge CLK);
    checkValue(0, int'(running), "running while stopped");
    @(posedge CLK);
    checkValue(readIdx, strobeLog.size(), "strobes while stopped");
  endtask

  task automatic runInstruction(input int idx, input bit withHalt);
    logic [11:0] word;
    int          modelAuto;
    int          modelInd;
    int          modelExec;
    int          gap;
    int          ph;
    int          step;
    int          expected [$];
    word      = traceWord[idx];
    modelAuto = isAutoIndexed(word);
    modelInd  = isIndirect(word);
    modelExec = execLength(word[11:9]);
    checkValue(modelAuto, traceAuto[idx], $sformatf("auto-index flag of line %0d", idx));
    checkValue(modelInd, traceInd[idx], $sformatf("indirect flag of line %0d", idx));
    checkValue(modelExec, traceExec[idx], $sformatf("exec count of line %0d", idx));
    expected.push_back(phFetch);
    if (modelAuto == 1) begin
      expected.push_back(phAuto1);
      expected.push_back(phAuto2);
    end
    if (modelInd == 1) begin
      expected.push_back(phInd);
    end
    for (step = 0; step < modelExec; step++) begin
      expected.push_back(phExec1 + step);
    end
    nextStrobedPhase(ph);
    checkValue(phFetch, ph, $sformatf("first strobed phase of line %0d", idx));
    // The word is latched on this edge, so the next one can follow
    @(posedge CLK);
    if (idx + 1 < traceWord.size()) begin
      instrWord <= traceWord[idx + 1];
    end
    if (withHalt) begin
      gap = {$random(seed)} % 6;
      repeat (gap) @(posedge CLK);
      halt <= 1'b1;
      @(posedge CLK);
      halt <= 1'b0;
    end
    for (step = 1; step < expected.size(); step++) begin
      nextStrobedPhase(ph);
      checkValue(expected[step], ph, $sformatf("strobed phase %0d of line %0d", step, idx));
    end
  endtask

  initial begin
    int idx;
    RESET      = 1'b1;
    run        = 1'b0;
    halt       = 1'b0;
    instrWord  = '0;
    readIdx    = 0;
    seed       = 32'h2b5497fb;
    loadTrace();
    // Halt test needs an instruction long enough to absorb the random gap
    haltIndex = -1;
    for (idx = traceWord.size() / 2; idx < traceWord.size(); idx++) begin
      if (haltIndex < 0 && 2 * isAutoIndexed(traceWord[idx]) + isIndirect(traceWord[idx])
          + execLength(traceWord[idx][11:9]) >= 4) begin
        haltIndex = idx;
      end
    end
    if (haltIndex < 0) begin
      $display("The trace holds no instruction long enough for the halt test");
      $display("TEST FAIL");
      $fatal(1, "Unusable trace");
    end
    fork
      monitorPhases();
      watchdog(traceWord.size() * 22 + 200);
    join_none
    repeat (3) @(posedge CLK);
    RESET     <= 1'b0;
    instrWord <= traceWord[0];
    @(negedge CLK);
    checkValue(0, int'(running), "running after reset");
    checkValue(0, int'(phaseWindow), "phase window after reset");
    checkValue(0, int'(phaseStrobe), "phase strobe after reset");
    checkValue(phIdle, int'(phase), "phase after reset");
    expectQuiet(8);
    // Too short for the debouncer
    applyRun(3);
    expectQuiet(10);
    applyRun(6);
    waitForRunning(1'b1);
    for (idx = 0; idx < traceWord.size(); idx++) begin
      runInstruction(idx, idx == haltIndex);
      if (idx == haltIndex) begin
        waitForRunning(1'b0);
        checkValue(phIdle, int'(phase), "phase after halt");
        expectQuiet(8);
        applyRun(6);
        waitForRunning(1'b1);
      end
    end
    $display("TEST PASS");
    $finish;
  end

endmodule

`default_nettype wire

// File: rtl/pdp8Control.sv
//--------------------------------------------------------------------------
// PDP-8 major-state timing unit: run control, sequencer and decoder
//--------------------------------------------------------------------------
`default_nettype none

module pdp8Control #(
  parameter int debounceCount = 16
) (
  input  logic              CLK,
  input  logic              RESET,
  input  logic              run,
  input  logic              halt,
  input  logic [11:0]       instrWord,
  output pdp8SeqPkg::phaseT phase,
  output logic              phaseWindow,
  output logic              phaseStrobe,
  output logic              running
);

  logic haltPending;
  logic atBoundary;

  seqBus bus ();

  runControl #(
    .debounceCount(debounceCount)
  ) runCtl (
    .CLK        (CLK),
    .RESET      (RESET),
    .run        (run),
    .halt       (halt),
    .atBoundary (atBoundary),
    .running    (running),
    .haltPending(haltPending)
  );

  majorStateSequencer sequencer (
    .CLK        (CLK),
    .RESET      (RESET),
    .running    (running),
    .haltPending(haltPending),
    .bus        (bus.sequencer),
    .atBoundary (atBoundary)
  );

  instructionDecoder decoder (
    .CLK      (CLK),
    .RESET    (RESET),
    .instrWord(instrWord),
    .bus      (bus.decoder)
  );

  assign phase       = bus.phase;
  assign phaseWindow = bus.phaseWindow;
  assign phaseStrobe = bus.phaseStrobe;

endmodule

`default_nettype wire

// File: rtl/majorStateSequencer.sv
//--------------------------------------------------------------------------
// Major-state step counter: two-cycle phases, Fetch routing and DONE
//--------------------------------------------------------------------------
`default_nettype none

module majorStateSequencer (
  input  logic      CLK,
  input  logic      RESET,
  input  logic      running,
  input  logic      haltPending,
  seqBus.sequencer  bus,
  output logic      atBoundary
);

  import pdp8SeqPkg::*;

  // Step layout: each phase owns an even/odd pair, odd is the strobe
  localparam logic [stepCountW-1:0] fetchStrobeStep = stepCountW'(1);
  localparam logic [stepCountW-1:0] auto1Step       = stepCountW'(2);
  localparam logic [stepCountW-1:0] indStep         = stepCountW'(6);
  localparam logic [stepCountW-1:0] exec1Step       = stepCountW'(8);
  localparam logic [stepCountW-1:0] lastWindowStep  = stepCountW'(19);
  localparam logic [stepCountW-1:0] idleStep        = '1;

  logic [stepCountW-1:0] stepCnt;
  logic [stepCountW-1:0] lastExecStrobe;
  logic                  done;
  logic                  inIdle;
  logic                  inWindow;

  // Strobe of ExecN sits at step 2*N+7
  assign lastExecStrobe = stepCountW'(7) + {1'b0, bus.execSteps, 1'b0};
  assign done           = (stepCnt == lastExecStrobe);
  assign inIdle         = (stepCnt == idleStep);
  assign atBoundary     = done | inIdle;

  always_ff @(posedge CLK) begin
    if (RESET) begin
      stepCnt <= idleStep;
    end else if (done) begin
      // Halt takes effect here so the instruction always completes
      if (haltPending || !running) begin
        stepCnt <= idleStep;
      end else begin
        stepCnt <= '0;
      end
    end else if (inIdle) begin
      if (running && !haltPending) begin
        stepCnt <= '0;
      end
    end else if (stepCnt == fetchStrobeStep) begin
      if (bus.seqType.isAutoIdx) begin
        stepCnt <= auto1Step;
      end else if (bus.seqType.isInd) begin
        stepCnt <= indStep;
      end else begin
        stepCnt <= exec1Step;
      end
    end else begin
      stepCnt <= stepCnt + 1'b1;
    end
  end

  // Auto2 runs straight into Ind by plain increment from step 5 to 6

  assign inWindow = (stepCnt <= lastWindowStep);

  always_comb begin
    if (inWindow) begin
      bus.phase = phaseT'(stepCnt[stepCountW-1:1]);
    end else begin
      bus.phase = phIdle;
    end
  end

  assign bus.phaseWindow = inWindow;
  assign bus.phaseStrobe = inWindow & stepCnt[0];

endmodule

`default_nettype wire

// File: rtl/instructionDecoder.sv
//--------------------------------------------------------------------------
// Instruction register and decode of the post-Fetch route and exec length
//--------------------------------------------------------------------------
`default_nettype none

module instructionDecoder (
  input  logic                  CLK,
  input  logic                  RESET,
  input  pdp8SeqPkg::instrWordT instrWord,
  seqBus.decoder                bus
);

  import pdp8SeqPkg::*;

  instrWordT  instrReg;
  instrWordT  decodeWord;
  logic       fetchStrobe;
  seqTypeT    routeType;
  logic [2:0] stepCount;

  assign fetchStrobe = bus.phaseStrobe && (bus.phase == phFetch);

  always_ff @(posedge CLK) begin
    if (RESET) begin
      instrReg <= '0;
    end else if (fetchStrobe) begin
      instrReg <= instrWord;
    end
  end

  // The jump at the Fetch strobe needs the incoming word, not the old one
  assign decodeWord = fetchStrobe ? instrWord : instrReg;

  always_comb begin
    routeType = '0;
    if (decodeWord.memRef.opcode == opIot || decodeWord.memRef.opcode == opOpr) begin
      // IOT and operate words never touch memory indirectly
      stepCount = execStepsFor(decodeWord.operate.opcode);
    end else begin
      stepCount        = execStepsFor(decodeWord.memRef.opcode);
      routeType.isInd  = decodeWord.memRef.indirect;
      // Page zero locations 010 to 017 are the auto-index registers
      routeType.isAutoIdx = decodeWord.memRef.indirect
                          & ~decodeWord.memRef.page
                          & (decodeWord.memRef.offset[6:3] == 4'b0001);
    end
  end

  assign bus.seqType   = routeType;
  assign bus.execSteps = stepCount;

endmodule

`default_nettype wire

// File: rtl/runControl.sv
//--------------------------------------------------------------------------
// Run/halt control: starts on a RUN edge, stops at an instruction boundary
//--------------------------------------------------------------------------
`default_nettype none

module runControl #(
  parameter int debounceCount = 16
) (
  input  logic CLK,
  input  logic RESET,
  input  logic run,
  input  logic halt,
  input  logic atBoundary,
  output logic running,
  output logic haltPending
);

  logic runStable;
  logic runStablePrev;
  logic runEdge;
  logic haltPrev;
  logic haltEdge;

  switchDebounce #(
    .debounceCount(debounceCount)
  ) runDebounce (
    .CLK        (CLK),
    .RESET      (RESET),
    .rawLevel   (run),
    .stableLevel(runStable)
  );

  // HALT is a synchronous request, only the edge detect is needed
  assign haltEdge = halt & ~haltPrev;

  always_ff @(posedge CLK) begin
    if (RESET) begin
      runStablePrev <= 1'b0;
      runEdge       <= 1'b0;
      haltPrev      <= 1'b0;
      running       <= 1'b0;
      haltPending   <= 1'b0;
    end else begin
      runStablePrev <= runStable;
      runEdge       <= runStable & ~runStablePrev;
      haltPrev      <= halt;

      if (atBoundary && haltPending) begin
        running <= 1'b0;
      end else if (runEdge && !running) begin
        running <= 1'b1;
      end

      // A fresh request in the boundary cycle survives for the next one
      haltPending <= haltEdge | (haltPending & ~atBoundary);
    end
  end

endmodule

`default_nettype wire

// File: rtl/switchDebounce.sv
//--------------------------------------------------------------------------
// Switch debouncer, accepts a new level once it has been stable long enough
//--------------------------------------------------------------------------
`default_nettype none

module switchDebounce #(
  parameter int debounceCount = 16
) (
  input  logic CLK,
  input  logic RESET,
  input  logic rawLevel,
  output logic stableLevel
);

  localparam int countW = $clog2(debounceCount + 1);

  logic [countW-1:0] agreeCount;

  always_ff @(posedge CLK) begin
    if (RESET) begin
      agreeCount  <= '0;
      stableLevel <= 1'b0;
    end else if (rawLevel == stableLevel) begin
      // Bounce back to the held level restarts the wait
      agreeCount <= '0;
    end else if (agreeCount == countW'(debounceCount - 1)) begin
      stableLevel <= rawLevel;
      agreeCount  <= '0;
    end else begin
      agreeCount <= agreeCount + 1'b1;
    end
  end

endmodule

`default_nettype wire

// File: rtl/seqBus.sv
//--------------------------------------------------------------------------
// Phase timing from the sequencer, route and exec length from the decoder
//--------------------------------------------------------------------------
`default_nettype none

interface seqBus;
  import pdp8SeqPkg::*;

  phaseT      phase;
  logic       phaseWindow;
  logic       phaseStrobe;
  seqTypeT    seqType;
  logic [2:0] execSteps;

  modport sequencer (
    output phase,
    output phaseWindow,
    output phaseStrobe,
    input  seqType,
    input  execSteps
  );

  modport decoder (
    output seqType,
    output execSteps,
    input  phase,
    input  phaseStrobe
  );

endinterface

`default_nettype wire

// File: rtl/pdp8SeqPkg.sv
//--------------------------------------------------------------------------
// PDP-8 major-state types: phases, opcodes, instruction views, exec lengths
//--------------------------------------------------------------------------
`default_nettype none

package pdp8SeqPkg;

  // Width of the major-state step counter
  parameter int stepCountW = 5;

  // Two-cycle major phases, Idle parks the machine while halted
  typedef enum logic [3:0] {
    phFetch = 4'd0,
    phAuto1 = 4'd1,
    phAuto2 = 4'd2,
    phInd   = 4'd3,
    phExec1 = 4'd4,
    phExec2 = 4'd5,
    phExec3 = 4'd6,
    phExec4 = 4'd7,
    phExec5 = 4'd8,
    phExec6 = 4'd9,
    phIdle  = 4'd15
  } phaseT;

  typedef enum logic [2:0] {
    opAnd = 3'd0,
    opTad = 3'd1,
    opIsz = 3'd2,
    opDca = 3'd3,
    opJms = 3'd4,
    opJmp = 3'd5,
    opIot = 3'd6,
    opOpr = 3'd7
  } opcodeT;

  // One 12-bit word, read as a memory reference or as an IOT/operate word
  typedef union packed {
    struct packed {
      opcodeT     opcode;
      logic       indirect;
      logic       page;
      logic [6:0] offset;
    } memRef;
    struct packed {
      opcodeT     opcode;
      logic [8:0] groupBits;
    } operate;
  } instrWordT;

  // Route after Fetch, same bit order as {autoIndex, indirect}
  typedef struct packed {
    logic isAutoIdx;
    logic isInd;
  } seqTypeT;

  // Number of exec phases each opcode needs
  function automatic logic [2:0] execStepsFor(opcodeT op);
    case (op)
      opAnd, opTad, opDca: execStepsFor = 3'd2;
      opIsz, opJms:        execStepsFor = 3'd3;
      opJmp:               execStepsFor = 3'd1;
      opIot:               execStepsFor = 3'd4;
      default:             execStepsFor = 3'd6;
    endcase
  endfunction

endpackage

`default_nettype wire
